//--- hw/invaders_geom_pkg.sv
package invaders_geom_pkg;

	////////////////////////////////////////////////////////////
	// Screen coordinates and pixels
	////////////////////////////////////////////////////////////

	// Wide enough for any common raster
	typedef logic [10:0] coord_t;

	// One scan position, active inside the visible window
	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   active;
	} pixel_pos_t;

	// Colour byte as the DAC expects it, blue on top
	typedef struct packed {
		logic [1:0] blue;
		logic [2:0] green;
		logic [2:0] red;
	} rgb_t;

	localparam rgb_t COLOR_ALIEN = 8'b10_101_010;
	localparam rgb_t COLOR_LASER = 8'b00_111_111;
	// Dark blue sky
	localparam rgb_t COLOR_BG    = 8'b01_000_000;

	////////////////////////////////////////////////////////////
	// Sprite geometry
	////////////////////////////////////////////////////////////

	// Alien box, centred on its position
	localparam coord_t ALIEN_LENGTH = 11'd30;
	localparam coord_t ALIEN_HEIGHT = 11'd16;

	// Laser box, x centred, y is the top row
	localparam coord_t LASER_LENGTH = 11'd3;
	localparam coord_t LASER_HEIGHT = 11'd10;

	// Movement per step
	localparam coord_t ALIEN_STEP_X = 11'd10;
	localparam coord_t ALIEN_STEP_Y = 11'd10;
	localparam coord_t LASER_STEP   = 11'd4;

	// Row layout
	localparam coord_t ALIEN_SPACING = 11'd40;
	localparam coord_t EDGE_MARGIN   = 11'd5;

endpackage

//--- hw/invaders_game_pkg.sv
package invaders_game_pkg;

	////////////////////////////////////////////////////////////
	// Game control encodings
	////////////////////////////////////////////////////////////

	// Top level game mode, attract and setup both restart the round
	typedef enum logic [1:0] {
		MODE_ATTRACT = 2'd0,
		MODE_SETUP   = 2'd1,
		MODE_PLAY    = 2'd2
	} game_mode_e;

	// March command to the row
	// Sideways codes also tell the row which way it is heading
	typedef enum logic [1:0] {
		STEP_NONE  = 2'd0,
		STEP_LEFT  = 2'd1,
		STEP_RIGHT = 2'd2,
		STEP_DOWN  = 2'd3
	} march_step_e;

	////////////////////////////////////////////////////////////
	// Object status
	////////////////////////////////////////////////////////////

	// Alien centre and life
	typedef struct packed {
		invaders_geom_pkg::coord_t x;
		invaders_geom_pkg::coord_t y;
		logic                      alive;
	} alien_status_t;

	// Laser position, top of the beam
	typedef struct packed {
		invaders_geom_pkg::coord_t x;
		invaders_geom_pkg::coord_t y;
		logic                      flying;
	} laser_status_t;

endpackage

//--- hw/pixel_scan.sv
module pixel_scan #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int H_TOTAL  = 800,
	parameter int V_TOTAL  = 525
) (
	input  logic                          clk,
	input  logic                          rst,
	output invaders_geom_pkg::pixel_pos_t pix,
	output logic                          frame_tick
);
	import invaders_geom_pkg::*;

	// Counter limits
	localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
	localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);
	localparam coord_t H_VIS  = coord_t'(H_ACTIVE);
	localparam coord_t V_VIS  = coord_t'(V_ACTIVE);

	coord_t h_cnt;
	coord_t v_cnt;
	logic   h_wrap;
	logic   v_wrap;

	assign h_wrap = (h_cnt == H_LAST);
	assign v_wrap = (v_cnt == V_LAST);

	always_ff @(posedge clk) begin
		if (rst) begin
			h_cnt      <= '0;
			v_cnt      <= '0;
			frame_tick <= 1'b0;
		end else begin
			// x moves every cycle
			h_cnt <= h_wrap ? '0 : h_cnt + 11'd1;
			// y moves at end of line
			if (h_wrap)
				v_cnt <= v_wrap ? '0 : v_cnt + 11'd1;
			// Registered so it lines up with the origin
			frame_tick <= h_wrap && v_wrap;
		end
	end

	assign pix = '{x: h_cnt, y: v_cnt, active: (h_cnt < H_VIS) && (v_cnt < V_VIS)};

endmodule

//--- hw/alien.sv
module alien #(
	parameter int INIT_X      = 80,
	parameter int INIT_Y      = 40,
	parameter int H_ACTIVE    = 640,
	parameter int BARRIER_TOP = 340
) (
	input  logic                             clk,
	input  logic                             rst,
	input  invaders_game_pkg::game_mode_e    mode,
	input  logic                             frame_tick,
	input  invaders_game_pkg::march_step_e   step,
	input  invaders_game_pkg::laser_status_t laser,
	input  invaders_geom_pkg::pixel_pos_t    pix,
	output invaders_game_pkg::alien_status_t status,
	output logic                             covers,
	output logic                             at_edge,
	output logic                             at_bottom,
	output logic                             hit
);
	import invaders_geom_pkg::*;
	import invaders_game_pkg::*;

	localparam coord_t HALF_L     = ALIEN_LENGTH / 2;
	localparam coord_t HALF_H     = ALIEN_HEIGHT / 2;
	// Reach of the laser box around its x and below its top
	localparam coord_t REACH_X    = HALF_L + LASER_LENGTH / 2;
	localparam coord_t REACH_Y    = HALF_H + LASER_HEIGHT - 11'd1;
	// Sideways limits, one step early
	localparam coord_t LEFT_LIM   = EDGE_MARGIN + HALF_L + ALIEN_STEP_X;
	localparam coord_t RIGHT_LIM  = coord_t'(H_ACTIVE) - EDGE_MARGIN;
	localparam coord_t BOTTOM_LIM = coord_t'(BARRIER_TOP);

	coord_t x;
	coord_t y;
	logic   alive;
	logic   moving_left;
	logic   laser_hits;

	// Laser box overlaps our box
	assign laser_hits = laser.flying && alive
		&& (laser.x + REACH_X >= x) && (laser.x <= x + REACH_X)
		&& (laser.y <= y + HALF_H) && (laser.y + REACH_Y >= y);

	always_ff @(posedge clk) begin
		// Single cycle pulse by default
		hit <= 1'b0;
		if (rst || mode != MODE_PLAY) begin
			// Back to the start slot
			x           <= coord_t'(INIT_X);
			y           <= coord_t'(INIT_Y);
			alive       <= 1'b1;
			moving_left <= 1'b0;
		end else begin
			// Hit test once per frame
			if (frame_tick && laser_hits) begin
				alive <= 1'b0;
				hit   <= 1'b1;
			end
			// Dead aliens stay put but still follow the heading
			case (step)
				STEP_RIGHT: begin
					if (alive)
						x <= x + ALIEN_STEP_X;
					moving_left <= 1'b0;
				end
				STEP_LEFT: begin
					if (alive)
						x <= x - ALIEN_STEP_X;
					moving_left <= 1'b1;
				end
				STEP_DOWN: begin
					if (alive)
						y <= y + ALIEN_STEP_Y;
					// Drop means turn around
					moving_left <= !moving_left;
				end
				default: ;
			endcase
		end
	end

	// Flags only count while alive
	assign at_edge = alive && (moving_left ? (x < LEFT_LIM) : (x + HALF_L + ALIEN_STEP_X > RIGHT_LIM));
	assign at_bottom = alive && (y + HALF_H >= BOTTOM_LIM);

	// Sprite box at the scan position
	assign covers = alive && pix.active
		&& (pix.x + HALF_L >= x) && (pix.x <= x + HALF_L)
		&& (pix.y + HALF_H >= y) && (pix.y <= y + HALF_H);

	assign status = '{x: x, y: y, alive: alive};

endmodule

//--- hw/alien_row.sv
module alien_row #(
	parameter int N_ALIENS    = 8,
	parameter int START_X     = 80,
	parameter int START_Y     = 40,
	parameter int H_ACTIVE    = 640,
	parameter int BARRIER_TOP = 340
) (
	input  logic                                            clk,
	input  logic                                            rst,
	input  invaders_game_pkg::game_mode_e                   mode,
	input  logic                                            frame_tick,
	input  invaders_game_pkg::march_step_e                  step,
	input  invaders_game_pkg::laser_status_t                laser,
	input  invaders_geom_pkg::pixel_pos_t                   pix,
	output invaders_game_pkg::alien_status_t [N_ALIENS-1:0] aliens,
	output logic                                            covers,
	output logic                                            any_edge,
	output logic                                            any_bottom,
	output logic                                            hit,
	output logic [1:0]                                      hit_count
);
	import invaders_geom_pkg::*;

	logic [N_ALIENS-1:0] cover_vec;
	logic [N_ALIENS-1:0] edge_vec;
	logic [N_ALIENS-1:0] bottom_vec;
	logic [N_ALIENS-1:0] hit_vec;
	logic [7:0]          hit_sum;

	// One alien per slot, spaced along x
	for (genvar i = 0; i < N_ALIENS; i++) begin : g_alien
		alien #(
			.INIT_X     (START_X + i * int'(ALIEN_SPACING)),
			.INIT_Y     (START_Y),
			.H_ACTIVE   (H_ACTIVE),
			.BARRIER_TOP(BARRIER_TOP)
		) alien_inst (
			.clk       (clk),
			.rst       (rst),
			.mode      (mode),
			.frame_tick(frame_tick),
			.step      (step),
			.laser     (laser),
			.pix       (pix),
			.status    (aliens[i]),
			.covers    (cover_vec[i]),
			.at_edge   (edge_vec[i]),
			.at_bottom (bottom_vec[i]),
			.hit       (hit_vec[i])
		);
	end

	// Row level flags
	assign covers     = |cover_vec;
	assign any_edge   = |edge_vec;
	assign any_bottom = |bottom_vec;
	assign hit        = |hit_vec;

	// Kills in this cycle, clipped to 3
	always_comb begin
		hit_sum = '0;
		for (int i = 0; i < N_ALIENS; i++)
			hit_sum = hit_sum + 8'(hit_vec[i]);
	end

	assign hit_count = (hit_sum > 8'd3) ? 2'd3 : hit_sum[1:0];

endmodule

//--- hw/alien_march.sv
module alien_march #(
	parameter int MOVE_FRAMES = 30
) (
	input  logic                           clk,
	input  logic                           rst,
	input  invaders_game_pkg::game_mode_e  mode,
	input  logic                           frame_tick,
	input  logic                           any_edge,
	input  logic                           any_bottom,
	output invaders_game_pkg::march_step_e step,
	output logic                           game_over
);
	import invaders_game_pkg::*;

	// Heading of the row
	typedef enum logic {
		DIR_RIGHT = 1'b0,
		DIR_LEFT  = 1'b1
	} dir_e;

	localparam int              CNT_W    = $clog2(MOVE_FRAMES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MOVE_FRAMES - 1);

	logic [CNT_W-1:0] frame_cnt;
	dir_e             dir;
	logic             period_done;

	// Last frame of a march period
	assign period_done = frame_tick && (frame_cnt == CNT_LAST);

	////////////////////////////////////////////////////////////
	// Step issue and game over
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || mode != MODE_PLAY) begin
			// Round restart
			frame_cnt <= '0;
			dir       <= DIR_RIGHT;
			step      <= STEP_NONE;
			game_over <= 1'b0;
		end else begin
			// Step is a one cycle command
			step <= STEP_NONE;
			// Sticky until next setup
			if (any_bottom)
				game_over <= 1'b1;
			// Row freezes once the game is lost
			if (frame_tick && !game_over) begin
				if (period_done) begin
					frame_cnt <= '0;
					if (any_edge) begin
						// Edge reached, drop and turn
						step <= STEP_DOWN;
						dir  <= (dir == DIR_RIGHT) ? DIR_LEFT : DIR_RIGHT;
					end else begin
						step <= (dir == DIR_RIGHT) ? STEP_RIGHT : STEP_LEFT;
					end
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
		end
	end

endmodule

//--- hw/laser.sv
module laser #(
	parameter int V_ACTIVE = 480
) (
	input  logic                             clk,
	input  logic                             rst,
	input  invaders_game_pkg::game_mode_e    mode,
	input  logic                             frame_tick,
	input  invaders_geom_pkg::coord_t        ship_x,
	input  logic                             fire_req,
	output logic                             fire_ack,
	input  logic                             hit,
	output invaders_game_pkg::laser_status_t status
);
	import invaders_geom_pkg::*;
	import invaders_game_pkg::*;

	// Four phase fire handshake
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,
		HS_RELEASE
	} hs_state_e;

	// Beam starts just above the bottom row
	localparam coord_t LAUNCH_Y = coord_t'(V_ACTIVE) - LASER_HEIGHT;

	hs_state_e hs_state;
	logic      flying;
	coord_t    pos_x;
	coord_t    pos_y;
	logic      accept;
	logic      retire;

	// Ack is low in idle, one shot at a time
	assign accept = (hs_state == HS_IDLE) && fire_req && (mode == MODE_PLAY) && !flying;
	// Next climb would pass the top
	assign retire = pos_y < LASER_STEP + LASER_STEP;

	always_ff @(posedge clk) begin
		if (rst) begin
			hs_state <= HS_IDLE;
			flying   <= 1'b0;
		end else begin
			case (hs_state)
				HS_IDLE:    if (accept) hs_state <= HS_ACK;
				// Hold ack until the requester lets go
				HS_ACK:     if (!fire_req) hs_state <= HS_RELEASE;
				HS_RELEASE: hs_state <= HS_IDLE;
				default:    hs_state <= HS_IDLE;
			endcase
			if (mode != MODE_PLAY || hit)
				flying <= 1'b0;
			else if (accept)
				flying <= 1'b1;
			else if (frame_tick && flying && retire)
				flying <= 1'b0;
		end
	end

	// Beam position
	always_ff @(posedge clk) begin
		if (accept) begin
			pos_x <= ship_x;
			pos_y <= LAUNCH_Y;
		end else if (frame_tick && flying && !retire) begin
			pos_y <= pos_y - LASER_STEP;
		end
	end

	assign fire_ack = (hs_state == HS_ACK);
	assign status   = '{x: pos_x, y: pos_y, flying: flying};

endmodule

//--- hw/frame_compose.sv
module frame_compose (
	input  logic                             clk,
	input  logic                             rst,
	input  invaders_game_pkg::game_mode_e    mode,
	input  invaders_geom_pkg::pixel_pos_t    pix,
	input  logic                             covers,
	input  invaders_game_pkg::laser_status_t laser,
	input  logic [1:0]                       hit_count,
	output invaders_geom_pkg::pixel_pos_t    pix_out,
	output invaders_geom_pkg::rgb_t          rgb,
	output logic [7:0]                       score
);
	import invaders_geom_pkg::*;
	import invaders_game_pkg::*;

	localparam coord_t LASER_HALF = LASER_LENGTH / 2;

	logic       in_laser;
	rgb_t       colour;
	logic [8:0] score_sum;

	// Beam box, top row is laser.y
	assign in_laser = laser.flying
		&& (pix.x + LASER_HALF >= laser.x) && (pix.x <= laser.x + LASER_HALF)
		&& (pix.y >= laser.y) && (pix.y < laser.y + LASER_HEIGHT);

	// Laser drawn over aliens
	always_comb begin
		if (!pix.active)
			colour = '0;
		else if (in_laser)
			colour = COLOR_LASER;
		else if (covers)
			colour = COLOR_ALIEN;
		else
			colour = COLOR_BG;
	end

	// Colour and its position leave together
	always_ff @(posedge clk) begin
		pix_out <= pix;
		rgb     <= colour;
	end

	// Score saturates at 255
	assign score_sum = {1'b0, score} + {7'b0, hit_count};

	always_ff @(posedge clk) begin
		if (rst || mode != MODE_PLAY)
			score <= '0;
		else
			score <= score_sum[8] ? 8'hFF : score_sum[7:0];
	end

endmodule

//--- hw/invaders_top.sv
module invaders_top #(
	parameter int H_ACTIVE    = 640,
	parameter int V_ACTIVE    = 480,
	parameter int H_TOTAL     = 800,
	parameter int V_TOTAL     = 525,
	parameter int N_ALIENS    = 8,
	parameter int MOVE_FRAMES = 30,
	parameter int START_X     = 80,
	parameter int START_Y     = 40,
	parameter int BARRIER_TOP = 340
) (
	input  logic                                            clk,
	input  logic                                            rst,
	input  invaders_game_pkg::game_mode_e                   mode,
	input  invaders_geom_pkg::coord_t                       ship_x,
	input  logic                                            fire_req,
	output logic                                            fire_ack,
	output invaders_geom_pkg::pixel_pos_t                   pix_out,
	output invaders_geom_pkg::rgb_t                         rgb,
	output invaders_game_pkg::alien_status_t [N_ALIENS-1:0] aliens,
	output invaders_game_pkg::laser_status_t                laser_out,
	output logic [7:0]                                      score,
	output logic                                            game_over,
	output logic                                            frame_tick
);
	import invaders_geom_pkg::*;
	import invaders_game_pkg::*;

	pixel_pos_t  pix;
	march_step_e step;
	logic        covers;
	logic        any_edge;
	logic        any_bottom;
	logic        hit;
	logic [1:0]  hit_count;

	////////////////////////////////////////////////////////////
	// Timing and movement
	////////////////////////////////////////////////////////////

	pixel_scan #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) pixel_scan_inst (
		.clk       (clk),
		.rst       (rst),
		.pix       (pix),
		.frame_tick(frame_tick)
	);

	alien_march #(
		.MOVE_FRAMES(MOVE_FRAMES)
	) alien_march_inst (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.frame_tick(frame_tick),
		.any_edge  (any_edge),
		.any_bottom(any_bottom),
		.step      (step),
		.game_over (game_over)
	);

	// Row reads the beam, beam retires on its hit
	alien_row #(
		.N_ALIENS   (N_ALIENS),
		.START_X    (START_X),
		.START_Y    (START_Y),
		.H_ACTIVE   (H_ACTIVE),
		.BARRIER_TOP(BARRIER_TOP)
	) alien_row_inst (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.frame_tick(frame_tick),
		.step      (step),
		.laser     (laser_out),
		.pix       (pix),
		.aliens    (aliens),
		.covers    (covers),
		.any_edge  (any_edge),
		.any_bottom(any_bottom),
		.hit       (hit),
		.hit_count (hit_count)
	);

	laser #(
		.V_ACTIVE(V_ACTIVE)
	) laser_inst (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.frame_tick(frame_tick),
		.ship_x    (ship_x),
		.fire_req  (fire_req),
		.fire_ack  (fire_ack),
		.hit       (hit),
		.status    (laser_out)
	);

	////////////////////////////////////////////////////////////
	// Video out and score
	////////////////////////////////////////////////////////////

	frame_compose frame_compose_inst (
		.clk      (clk),
		.rst      (rst),
		.mode     (mode),
		.pix      (pix),
		.covers   (covers),
		.laser    (laser_out),
		.hit_count(hit_count),
		.pix_out  (pix_out),
		.rgb      (rgb),
		.score    (score)
	);

endmodule

//--- verification/invaders_assertions.sv
module invaders_assertions (
	input logic                          clk,
	input logic                          rst,
	input invaders_game_pkg::game_mode_e mode,
	input logic                          fire_req,
	input logic                          fire_ack,
	input logic [7:0]                    score,
	input logic                          game_over
);
	timeunit 1ns;
	timeprecision 1ps;
	import invaders_game_pkg::*;

	logic in_play;

	assign in_play = (mode == MODE_PLAY);

	////////////////////////////////////////////////////////////
	// Fire handshake
	////////////////////////////////////////////////////////////

	// Ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (rst)
		$rose(fire_ack) |-> $past(fire_req))
		else $error("fire_ack rose with no fire_req pending");

	// Ack held until the requester lets go
	ack_held: assert property (@(posedge clk) disable iff (rst)
		(fire_ack && fire_req) |=> fire_ack)
		else $error("fire_ack dropped while fire_req was still high");

	////////////////////////////////////////////////////////////
	// Game rules
	////////////////////////////////////////////////////////////

	// Score only counts up during a round
	score_up: assert property (@(posedge clk) disable iff (rst)
		(in_play && $past(in_play)) |-> (score >= $past(score)))
		else $error("score went down during play");

	// Lost game stays lost until setup
	over_sticky: assert property (@(posedge clk) disable iff (rst)
		(in_play && $past(in_play) && $past(game_over)) |-> game_over)
		else $error("game_over cleared during play");

endmodule

bind invaders_top invaders_assertions invaders_assertions_inst (
	.clk      (clk),
	.rst      (rst),
	.mode     (mode),
	.fire_req (fire_req),
	.fire_ack (fire_ack),
	.score    (score),
	.game_over(game_over)
);

//--- verification/invaders_tb.sv
module invaders_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import invaders_geom_pkg::*;
	import invaders_game_pkg::*;

	// Small screen keeps frames short
	localparam int H_ACTIVE     = 160;
	localparam int V_ACTIVE     = 60;
	localparam int H_TOTAL      = 180;
	localparam int V_TOTAL      = 64;
	localparam int N_ALIENS     = 3;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam string STIM_FILE = "verification/invaders_stim.txt";

	logic                         clk;
	logic                         rst;
	game_mode_e                   mode;
	coord_t                       ship_x;
	logic                         fire_req;
	logic                         fire_ack;
	pixel_pos_t                   pix_out;
	rgb_t                         rgb;
	alien_status_t [N_ALIENS-1:0] aliens;
	laser_status_t                laser_out;
	logic [7:0]                   score;
	logic                         game_over;
	logic                         frame_tick;

	int value_errors = 0;
	int other_errors = 0;
	int cycle_count  = 0;
	int cycle_limit  = 0;
	int total_frames;

	// Outputs seen one cycle earlier, for the colour model
	alien_status_t [N_ALIENS-1:0] prev_aliens;
	laser_status_t                prev_laser;
	logic                         prev_valid = 1'b0;

	invaders_top #(
		.H_ACTIVE   (H_ACTIVE),
		.V_ACTIVE   (V_ACTIVE),
		.H_TOTAL    (H_TOTAL),
		.V_TOTAL    (V_TOTAL),
		.N_ALIENS   (N_ALIENS),
		.MOVE_FRAMES(2),
		.START_X    (40),
		.START_Y    (12),
		.BARRIER_TOP(52)
	) invaders_top_inst (
		.clk       (clk),
		.rst       (rst),
		.mode      (mode),
		.ship_x    (ship_x),
		.fire_req  (fire_req),
		.fire_ack  (fire_ack),
		.pix_out   (pix_out),
		.rgb       (rgb),
		.aliens    (aliens),
		.laser_out (laser_out),
		.score     (score),
		.game_over (game_over),
		.frame_tick(frame_tick)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_alien(input string name, input alien_status_t exp,
			input alien_status_t act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected x=%0d y=%0d alive=%0b, actual x=%0d y=%0d alive=%0b",
				name, exp.x, exp.y, exp.alive, act.x, act.y, act.alive);
		end
	endtask

	task automatic check_laser(input string name, input laser_status_t exp,
			input laser_status_t act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected x=%0d y=%0d flying=%0b, actual x=%0d y=%0d flying=%0b",
				name, exp.x, exp.y, exp.flying, act.x, act.y, act.flying);
		end
	endtask

	task automatic check_score(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_over(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_tick(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
		if (exp !== act) begin
			value_errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Colour model
	////////////////////////////////////////////////////////////

	// Priority: blank, laser, alien, sky
	function automatic rgb_t expected_colour(input pixel_pos_t p,
			input alien_status_t [N_ALIENS-1:0] row, input laser_status_t las);
		int   i;
		int   dx;
		int   dy;
		logic on_alien;
		if (!p.active)
			return '0;
		dx = int'(p.x) - int'(las.x);
		dy = int'(p.y) - int'(las.y);
		if (las.flying && dx >= -1 && dx <= 1 && dy >= 0 && dy < int'(LASER_HEIGHT))
			return COLOR_LASER;
		on_alien = 1'b0;
		for (i = 0; i < N_ALIENS; i++) begin
			dx = int'(p.x) - int'(row[i].x);
			dy = int'(p.y) - int'(row[i].y);
			// Box centred on the alien
			if (row[i].alive && dx >= -15 && dx <= 15 && dy >= -8 && dy <= 8)
				on_alien = 1'b1;
		end
		return on_alien ? COLOR_ALIEN : COLOR_BG;
	endfunction

	// rgb leaves one cycle after the pixel it belongs to
	always @(negedge clk) begin
		if (rst) begin
			prev_valid = 1'b0;
		end else begin
			if (prev_valid) begin
				check_rgb($sformatf("pixel %0d,%0d", pix_out.x, pix_out.y),
					expected_colour(pix_out, prev_aliens, prev_laser), rgb);
				// Tick marks the origin, one pixel after the last one of the frame
				check_tick($sformatf("frame_tick after %0d,%0d", pix_out.x, pix_out.y),
					(int'(pix_out.x) == H_TOTAL - 1) && (int'(pix_out.y) == V_TOTAL - 1),
					frame_tick);
			end
			prev_aliens = aliens;
			prev_laser  = laser_out;
			prev_valid  = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus actions
	////////////////////////////////////////////////////////////

	task automatic set_mode(input string word);
		@(negedge clk);
		if (word == "PLAY")
			mode = MODE_PLAY;
		else if (word == "SETUP")
			mode = MODE_SETUP;
		else if (word == "ATTRACT")
			mode = MODE_ATTRACT;
		else begin
			other_errors++;
			$display("ERROR: unknown mode %s in stimulus file", word);
		end
		// Let the round restart settle
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_frames(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk);
			if (frame_tick)
				seen++;
		end
		// Step lands two cycles after the tick, flags one later
		repeat (4) @(negedge clk);
	endtask

	task automatic fire(input int x);
		logic saw_idle;
		@(negedge clk);
		ship_x   = coord_t'(x);
		saw_idle = !laser_out.flying;
		fire_req = 1'b1;
		while (!fire_ack) begin
			@(negedge clk);
			if (!fire_ack && !laser_out.flying)
				saw_idle = 1'b1;
		end
		// Back pressure while a beam is up
		if (!saw_idle) begin
			other_errors++;
			$display("ERROR: fire was acknowledged while the laser was still flying");
		end
		// Beam launched above the ship on the ack edge
		check_laser($sformatf("launch at %0d", x),
			'{x: coord_t'(x), y: coord_t'(V_ACTIVE - 10), flying: 1'b1}, laser_out);
		@(negedge clk);
		fire_req = 1'b0;
		while (fire_ack)
			@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// Stim file interpreter
	////////////////////////////////////////////////////////////

	// Dry pass only sums the frames waited
	task automatic process_stim(input bit execute, output int frames);
		int             fd;
		int             n;
		int             idx;
		int             a;
		int             b;
		int             c;
		int             d;
		string          cmd;
		string          word;
		logic [1023:0]  rest;
		frames = 0;
		idx    = 0;
		fd     = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			other_errors++;
			$display("ERROR: cannot open stimulus file %s", STIM_FILE);
			return;
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			idx++;
			if (cmd.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
			end else if (cmd == "MODE") begin
				n = $fscanf(fd, "%s", word);
				if (execute)
					set_mode(word);
			end else if (cmd == "WAIT_FRAMES") begin
				n = $fscanf(fd, "%d", a);
				frames += a;
				if (execute)
					wait_frames(a);
			end else if (cmd == "FIRE") begin
				n = $fscanf(fd, "%d", a);
				if (execute)
					fire(a);
			end else if (cmd == "EXPECT_ALIEN") begin
				n = $fscanf(fd, "%d %d %d %d", a, b, c, d);
				if (execute && (a < 0 || a >= N_ALIENS)) begin
					other_errors++;
					$display("ERROR: alien index %0d out of range in command %0d", a, idx);
				end else if (execute) begin
					check_alien($sformatf("cmd %0d alien %0d", idx, a),
						'{x: coord_t'(b), y: coord_t'(c), alive: (d != 0)}, aliens[a]);
				end
			end else if (cmd == "EXPECT_SCORE") begin
				n = $fscanf(fd, "%d", a);
				if (execute)
					check_score($sformatf("cmd %0d score", idx), 8'(a), score);
			end else if (cmd == "EXPECT_OVER") begin
				n = $fscanf(fd, "%d", a);
				if (execute)
					check_over($sformatf("cmd %0d game_over", idx), (a != 0), game_over);
			end else if (execute) begin
				other_errors++;
				$display("ERROR: unknown command %s in stimulus file", cmd);
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////

	initial begin
		rst      = 1'b1;
		mode     = MODE_SETUP;
		ship_x   = '0;
		fire_req = 1'b0;
		process_stim(1'b0, total_frames);
		cycle_limit = total_frames * FRAME_CYCLES * 2 + 1000;
		repeat (8) @(negedge clk);
		rst = 1'b0;
		process_stim(1'b1, total_frames);
		$display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Hang guard
	initial begin
		wait (cycle_limit > 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: run did not finish within %0d cycles", cycle_limit);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

//--- verification/invaders_stim.txt
# One command per line: MODE word | WAIT_FRAMES n | FIRE ship_x
# EXPECT_ALIEN index x y alive | EXPECT_SCORE value | EXPECT_OVER value
EXPECT_ALIEN 0 40 12 1
EXPECT_ALIEN 1 80 12 1
EXPECT_ALIEN 2 120 12 1
EXPECT_SCORE 0
EXPECT_OVER 0
MODE PLAY
WAIT_FRAMES 2
EXPECT_ALIEN 0 50 12 1
EXPECT_ALIEN 2 130 12 1
WAIT_FRAMES 2
EXPECT_ALIEN 2 140 12 1
WAIT_FRAMES 2
EXPECT_ALIEN 2 140 22 1
WAIT_FRAMES 2
EXPECT_ALIEN 0 50 22 1
FIRE 70
WAIT_FRAMES 6
EXPECT_ALIEN 0 20 22 1
EXPECT_ALIEN 1 70 22 0
EXPECT_ALIEN 2 100 22 1
EXPECT_SCORE 1
FIRE 158
FIRE 158
EXPECT_SCORE 1
MODE SETUP
EXPECT_ALIEN 1 80 12 1
EXPECT_SCORE 0
MODE PLAY
WAIT_FRAMES 36
EXPECT_ALIEN 0 20 52 1
EXPECT_ALIEN 2 100 52 1
EXPECT_OVER 1
WAIT_FRAMES 4
EXPECT_ALIEN 0 20 52 1
EXPECT_OVER 1
MODE SETUP
EXPECT_ALIEN 0 40 12 1
EXPECT_SCORE 0
EXPECT_OVER 0

//--- list.f
hw/invaders_geom_pkg.sv
hw/invaders_game_pkg.sv
hw/pixel_scan.sv
hw/alien.sv
hw/alien_row.sv
hw/alien_march.sv
hw/laser.sv
hw/frame_compose.sv
hw/invaders_top.sv
verification/invaders_assertions.sv
verification/invaders_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = invaders_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
